//--- build.f
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/cpu_core.sv
tests/cpu_checker.sv
tests/tb_cpu_core.sv

//--- Makefile
TOP = tb_cpu_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f build.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^Regression passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

	localparam int num_instr    = 2000;
	localparam int reset_cycles = 5;
	localparam int drain_cycles = 20;
	localparam int clk_period   = 40;
	localparam int timeout_ns   = (num_instr + reset_cycles + drain_cycles) * clk_period * 2;
	localparam logic [15:0] lfsr_seed = 16'd55286;

	logic clk = 1'b0;
	logic reset;
	logic instr_valid;
	logic [instr_w-1:0] instr;
	wb_t wb;
	logic [reg_value_w-1:0] debug_out;

	logic [15:0] lfsr_state;
	// Two most recent destinations steer sources into forwarding
	logic [reg_addr_w-1:0] last_rd [2];

	always #(clk_period/2) clk = ~clk;

	cpu_core i_cpu_core (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.debug_out   (debug_out)
	);

	cpu_checker i_cpu_checker (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.debug_out   (debug_out)
	);

	//////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////

	// Taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[14:0], lfsr_state[0]};
		end
	endtask

	task automatic pick_source(output logic [reg_addr_w-1:0] addr);
		logic [15:0] bits;
		take_bits(2, bits);
		case (bits[1:0])
			2'd0: addr = last_rd[0];
			2'd1: addr = last_rd[1];
			default: begin
				take_bits(reg_addr_w, bits);
				addr = bits[reg_addr_w-1:0];
			end
		endcase
	endtask

	task automatic make_instr(output logic valid, output logic [instr_w-1:0] word);
		logic [15:0] bits;
		logic [op_w-1:0] op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		take_bits(3, bits);
		valid = (bits[2:0] != 3'd0);
		// Fold codes 10 to 13 onto shifts and immediates
		// Codes 14 and 15 stay unknown
		take_bits(op_w, bits);
		op = bits[op_w-1:0];
		if (op >= 4'd10 && op < 4'd14) begin
			op = op - 4'd4;
		end
		take_bits(reg_addr_w, bits);
		rd = bits[reg_addr_w-1:0];
		pick_source(rs1);
		pick_source(rs2);
		word = '0;
		word[op_lsb +: op_w] = op;
		word[rd_lsb +: reg_addr_w] = rd;
		word[rs1_lsb +: reg_addr_w] = rs1;
		if (op == op_addi) begin
			take_bits(imm6_w, bits);
			word[imm6_lsb +: imm6_w] = bits[imm6_w-1:0];
		end else if (op == op_ldi) begin
			take_bits(imm8_w, bits);
			word[imm8_lsb +: imm8_w] = bits[imm8_w-1:0];
		end else begin
			word[rs2_lsb +: reg_addr_w] = rs2;
			take_bits(3, bits);
			word[2:0] = bits[2:0];
		end
		if (valid) begin
			last_rd[1] = last_rd[0];
			last_rd[0] = rd;
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus and report
	//////////////////////////////////////////////////

	initial begin
		logic v;
		logic [instr_w-1:0] w;
		lfsr_state = lfsr_seed;
		last_rd[0] = 3'd1;
		last_rd[1] = 3'd2;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		for (int n = 0; n < num_instr; n++) begin
			make_instr(v, w);
			instr_valid <= v;
			instr <= w;
			@(posedge clk);
		end
		instr_valid <= 1'b0;
		// Let the checker drain its expectation queue
		do begin
			@(negedge clk);
		end while (i_cpu_checker.pending != 0);
		repeat (2) @(negedge clk);
		$display("Errors: %0d value, %0d protocol", i_cpu_checker.value_errors,
			i_cpu_checker.protocol_errors);
		if (i_cpu_checker.value_errors + i_cpu_checker.protocol_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("Simulation timed out after %0d ns", timeout_ns);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- tests/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   instr_valid,
	input  logic [instr_w-1:0]     instr,
	input  wb_t                    wb,
	input  logic [reg_value_w-1:0] debug_out
);

	typedef struct packed {
		logic [31:0]            due;
		logic [reg_addr_w-1:0]  addr;
		logic [reg_value_w-1:0] value;
	} expect_t;

	expect_t expect_q [$];

	// Registers as the instruction stream sees them, and as written back
	logic [reg_value_w-1:0] arch_regs [num_regs];
	logic [reg_value_w-1:0] commit_regs [num_regs];

	logic [31:0] cycle = '0;
	int value_errors = 0;
	int protocol_errors = 0;
	int pending = 0;

	function automatic logic [reg_value_w-1:0] model_result(
		input logic [op_w-1:0]        op,
		input logic [reg_value_w-1:0] a,
		input logic [reg_value_w-1:0] b
	);
		logic [reg_value_w-1:0] r;
		case (op)
			op_add:  r = a + b;
			op_sub:  r = a - b;
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_xor:  r = a ^ b;
			op_shl:  r = a << b[3:0];
			op_shr:  r = a >> b[3:0];
			op_addi: r = a + b;
			op_ldi:  r = b;
			default: r = '0;
		endcase
		return r;
	endfunction

	always @(posedge clk) begin : check_cycle
		expect_t head;
		expect_t item;
		logic [op_w-1:0] op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_value_w-1:0] a;
		logic [reg_value_w-1:0] b;
		cycle = cycle + 32'd1;
		if (reset) begin
			expect_q.delete();
			for (int i = 0; i < num_regs; i++) begin
				arch_regs[i] = '0;
				commit_regs[i] = '0;
			end
		end else begin
			// Register 1 as of the last committed writeback
			if (debug_out !== commit_regs[1]) begin
				value_errors++;
				$display("Fail %0t: debug_out %h, expected %h", $time, debug_out,
					commit_regs[1]);
			end

			if (wb.valid !== 1'b0) begin
				if (expect_q.size() == 0) begin
					protocol_errors++;
					$display("Writeback to r%0d at %0t ns but no instruction expects one",
						wb.addr, $time);
				end else begin
					head = expect_q.pop_front();
					if (head.due != cycle || wb.addr !== head.addr || wb.value !== head.value) begin
						value_errors++;
						$display("Fail %0t: wb r%0d=%h in cycle %0d, expected r%0d=%h in cycle %0d",
							$time, wb.addr, wb.value, cycle, head.addr, head.value, head.due);
					end
					commit_regs[head.addr] = head.value;
				end
			end else if (expect_q.size() != 0 && expect_q[0].due == cycle) begin
				protocol_errors++;
				head = expect_q.pop_front();
				$display("Writeback of r%0d missing at %0t ns", head.addr, $time);
				commit_regs[head.addr] = head.value;
			end

			// New instruction, executed in program order on the model
			if (instr_valid) begin
				op = instr[op_lsb +: op_w];
				rd = instr[rd_lsb +: reg_addr_w];
				a = arch_regs[instr[rs1_lsb +: reg_addr_w]];
				if (op == op_addi) begin
					b = {{(reg_value_w-imm6_w){instr[imm6_lsb+imm6_w-1]}},
						instr[imm6_lsb +: imm6_w]};
				end else if (op == op_ldi) begin
					b = {{(reg_value_w-imm8_w){1'b0}}, instr[imm8_lsb +: imm8_w]};
				end else begin
					b = arch_regs[instr[rs2_lsb +: reg_addr_w]];
				end
				if (op != op_nop && op <= op_ldi && rd != 3'd0) begin
					item.due = cycle + 32'd3;
					item.addr = rd;
					item.value = model_result(op, a, b);
					arch_regs[rd] = item.value;
					expect_q.push_back(item);
				end
			end
		end
		pending = expect_q.size();
	end

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   instr_valid,
	input  logic [instr_w-1:0]     instr,

	output wb_t                    wb,
	output logic [reg_value_w-1:0] debug_out
);

	decoded_t dec;
	decoded_t dec_q;
	exec_t ex_d;
	exec_t ex_q;
	wb_t alu_fwd;
	wb_t wb_q;

	logic [reg_value_w-1:0] read_value1;
	logic [reg_value_w-1:0] read_value2;
	logic [reg_value_w-1:0] alu_result;
	logic use_imm;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	decoder i_decoder (
		.instr       (instr),
		.instr_valid (instr_valid),
		.dec         (dec)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_q.valid <= 1'b0;
			dec_q.wr_en <= 1'b0;
		end else if (instr_valid) begin
			dec_q <= dec;
		end else begin
			// Bubble
			dec_q.valid <= 1'b0;
			dec_q.wr_en <= 1'b0;
		end
	end

	// Register read with forwarding from execute and writeback
	register_file i_register_file (
		.clk         (clk),
		.reset       (reset),
		.wb_port     (wb_q),
		.alu_fwd     (alu_fwd),
		.read_addr1  (dec_q.rs1),
		.read_addr2  (dec_q.rs2),
		.read_value1 (read_value1),
		.read_value2 (read_value2),
		.debug_out   (debug_out)
	);

	// Immediate forms take imm in place of rs2
	assign use_imm = (dec_q.op == op_addi) || (dec_q.op == op_ldi);

	always_comb begin
		ex_d.op        = dec_q.op;
		ex_d.wr_en     = dec_q.valid && dec_q.wr_en;
		ex_d.rd        = dec_q.rd;
		ex_d.operand_a = read_value1;
		ex_d.operand_b = use_imm ? dec_q.imm : read_value2;
		ex_d.imm       = dec_q.imm;
	end

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_q.wr_en <= 1'b0;
		end else begin
			ex_q <= ex_d;
		end
	end

	alu i_alu (
		.ex     (ex_q),
		.result (alu_result)
	);

	// Result in flight, seen by decode in the same cycle
	always_comb begin
		alu_fwd.valid = ex_q.wr_en;
		alu_fwd.addr  = ex_q.rd;
		alu_fwd.value = alu_result;
	end

	//////////////////////////////////////////////////
	// Writeback
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_q.valid <= 1'b0;
		end else begin
			wb_q <= alu_fwd;
		end
	end

	assign wb = wb_q;

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  exec_t                  ex,
	output logic [reg_value_w-1:0] result
);

	// Shift amount from the low bits of rs2
	localparam int shamt_w = 4;

	logic [shamt_w-1:0] shamt;

	assign shamt = ex.operand_b[shamt_w-1:0];

	always_comb begin
		case (ex.op)
			// Wrapping arithmetic
			op_add: begin
				result = ex.operand_a + ex.operand_b;
			end
			op_sub: begin
				result = ex.operand_a - ex.operand_b;
			end

			// Bitwise
			op_and: begin
				result = ex.operand_a & ex.operand_b;
			end
			op_or: begin
				result = ex.operand_a | ex.operand_b;
			end
			op_xor: begin
				result = ex.operand_a ^ ex.operand_b;
			end

			// Logical shifts, zero fill
			op_shl: begin
				result = ex.operand_a << shamt;
			end
			op_shr: begin
				result = ex.operand_a >> shamt;
			end

			// Immediate forms
			op_addi: begin
				result = ex.operand_a + ex.imm;
			end
			op_ldi: begin
				result = ex.imm;
			end

			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,

	// Write port, also the older forwarding source
	input  wb_t                    wb_port,
	// Result currently in execute
	input  wb_t                    alu_fwd,

	input  logic [reg_addr_w-1:0]  read_addr1,
	input  logic [reg_addr_w-1:0]  read_addr2,
	output logic [reg_value_w-1:0] read_value1,
	output logic [reg_value_w-1:0] read_value2,

	output logic [reg_value_w-1:0] debug_out
);

	// Register 0 has no storage
	logic [reg_value_w-1:0] regs [num_regs-1:1];

	// Full view with the zero register in slot 0
	logic [reg_value_w-1:0] stored [num_regs];

	// Youngest result wins, then writeback, then storage
	function automatic logic [reg_value_w-1:0] resolve_read(
		input logic [reg_addr_w-1:0]  addr,
		input wb_t                    young,
		input wb_t                    old,
		input logic [reg_value_w-1:0] stored_value
	);
		logic [reg_value_w-1:0] value;
		if (young.valid && (young.addr == addr)) begin
			value = young.value;
		end else if (old.valid && (old.addr == addr)) begin
			value = old.value;
		end else begin
			value = stored_value;
		end
		return value;
	endfunction

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 1; i < num_regs; i++) begin
				if (wb_port.valid && (wb_port.addr == reg_addr_w'(i))) begin
					regs[i] <= wb_port.value;
				end
			end
		end
	end

	always_comb begin
		stored[zero_reg] = '0;
		for (int i = 1; i < num_regs; i++) begin
			stored[i] = regs[i];
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Neither bus is ever valid for register 0, so it reads zero
	assign read_value1 = resolve_read(read_addr1, alu_fwd, wb_port, stored[read_addr1]);
	assign read_value2 = resolve_read(read_addr2, alu_fwd, wb_port, stored[read_addr2]);

	assign debug_out = regs[1];

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
	input  logic [instr_w-1:0] instr,
	input  logic               instr_valid,
	output decoded_t           dec
);

	logic [op_w-1:0] op_raw;
	logic [imm6_w-1:0] imm6;
	logic [imm8_w-1:0] imm8;
	opcode_e op;
	logic writes;

	assign op_raw = instr[op_lsb +: op_w];
	assign imm6 = instr[imm6_lsb +: imm6_w];
	assign imm8 = instr[imm8_lsb +: imm8_w];

	// Opcode map, unknown codes become NOP
	always_comb begin
		case (op_raw)
			op_add, op_sub, op_and, op_or, op_xor,
			op_shl, op_shr, op_addi, op_ldi: begin
				op = opcode_e'(op_raw);
			end
			default: begin
				op = op_nop;
			end
		endcase
	end

	// Everything except NOP writes rd
	assign writes = (op != op_nop);

	always_comb begin
		dec.valid = instr_valid;
		dec.op    = op;
		dec.rd    = instr[rd_lsb +: reg_addr_w];
		dec.rs1   = instr[rs1_lsb +: reg_addr_w];
		dec.rs2   = instr[rs2_lsb +: reg_addr_w];

		// Register 0 writes dropped here, once for the whole pipe
		dec.wr_en = instr_valid && writes && (dec.rd != zero_reg);

		case (op)
			op_addi: begin
				// Sign extended
				dec.imm = {{(reg_value_w-imm6_w){imm6[imm6_w-1]}}, imm6};
			end
			op_ldi: begin
				// Zero extended
				dec.imm = {{(reg_value_w-imm8_w){1'b0}}, imm8};
			end
			default: begin
				dec.imm = '0;
			end
		endcase
	end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////

	localparam int reg_addr_w  = 3;
	localparam int reg_value_w = 16;
	localparam int num_regs    = 8;
	localparam int instr_w     = 16;

	// Hard-wired zero register
	localparam logic [reg_addr_w-1:0] zero_reg = '0;

	//////////////////////////////////////////////////
	// Instruction fields, low bit of each
	//////////////////////////////////////////////////

	localparam int op_w     = 4;
	localparam int op_lsb   = 12;
	localparam int rd_lsb   = 9;
	localparam int rs1_lsb  = 6;
	localparam int rs2_lsb  = 3;
	localparam int imm6_w   = 6;
	localparam int imm6_lsb = 0;
	localparam int imm8_w   = 8;
	localparam int imm8_lsb = 0;

	// Codes above op_ldi decode as op_nop
	typedef enum logic [op_w-1:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_shl  = 4'd6,
		op_shr  = 4'd7,
		op_addi = 4'd8,
		op_ldi  = 4'd9
	} opcode_e;

	//////////////////////////////////////////////////
	// Pipeline structs
	//////////////////////////////////////////////////

	// Decode stage, wr_en already excludes register 0
	typedef struct packed {
		logic                   valid;
		opcode_e                op;
		logic                   wr_en;
		logic [reg_addr_w-1:0]  rd;
		logic [reg_addr_w-1:0]  rs1;
		logic [reg_addr_w-1:0]  rs2;
		logic [reg_value_w-1:0] imm;
	} decoded_t;

	// Execute stage, operands already forwarded
	typedef struct packed {
		opcode_e                op;
		logic                   wr_en;
		logic [reg_addr_w-1:0]  rd;
		logic [reg_value_w-1:0] operand_a;
		logic [reg_value_w-1:0] operand_b;
		logic [reg_value_w-1:0] imm;
	} exec_t;

	// Forwarding and writeback bus
	typedef struct packed {
		logic                   valid;
		logic [reg_addr_w-1:0]  addr;
		logic [reg_value_w-1:0] value;
	} wb_t;

endpackage
